// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := gbc_io_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/gbc_io_pkg.sv
`default_nettype none

`include "gbc_io_params.svh"

package gbc_io_pkg;

   // ==================================================
   // Slot numbering
   // ==================================================

   // One extra value past the bank selects the heartbeat
   typedef logic [$clog2(`GBC_NUM_IOREGS + 1)-1:0] reg_idx_t;

   // ==================================================
   // Bus and decoded access
   // ==================================================

   // CPU side request with active-low strobes
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        we_l;
      logic        re_l;
   } io_bus_t;

   // Request after address match
   typedef struct packed {
      reg_idx_t    slot;
      logic        write;
      logic        read;
      logic        hit;
      logic [7:0]  wdata;
   } reg_access_t;

   // Whole bank, slot 0 in the low byte
   typedef logic [`GBC_NUM_IOREGS-1:0][7:0] reg_bank_t;

endpackage

`default_nettype wire

// File: design/gbc_io_top.sv
`default_nettype none

`include "gbc_io_params.svh"

module gbc_io_top #(
   parameter int HEARTBEAT_BITS = `GBC_HEARTBEAT_BITS
) (
   input  logic                clock_in,
   input  logic                synch_reset,
   input  gbc_io_pkg::io_bus_t bus,
   input  logic [7:0]          debug_select,
   output logic [7:0]          read_data,
   output logic                read_valid,
   output logic [7:0]          debug_value
);

   gbc_io_pkg::reg_access_t access;
   gbc_io_pkg::reg_bank_t   bank;
   logic [7:0]              heartbeat;

   // ==================================================
   // Address match
   // ==================================================
   ioreg_decode decode0 (
      .bus    (bus),
      .access (access)
   );

   // Bank update and heartbeat
   ioreg_file #(
      .HEARTBEAT_BITS (HEARTBEAT_BITS)
   ) regs0 (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .access      (access),
      .bank        (bank),
      .heartbeat   (heartbeat)
   );

   // ==================================================
   // Read data and debug view
   // ==================================================
   ioreg_readback readback0 (
      .clock_in     (clock_in),
      .synch_reset  (synch_reset),
      .access       (access),
      .bank         (bank),
      .heartbeat    (heartbeat),
      .debug_select (debug_select),
      .read_data    (read_data),
      .read_valid   (read_valid),
      .debug_value  (debug_value)
   );

endmodule

`default_nettype wire

// File: design/ioreg_decode.sv
`default_nettype none

`include "gbc_io_params.svh"

module ioreg_decode (
   input  gbc_io_pkg::io_bus_t     bus,
   output gbc_io_pkg::reg_access_t access
);

   // Low address bytes, slot 0 rightmost
   localparam logic [`GBC_NUM_IOREGS-1:0][7:0] ADDR_TABLE = {
      `GBC_ADDR_FF77,
      `GBC_ADDR_FF76,
      `GBC_ADDR_FF75,
      `GBC_ADDR_FF74,
      `GBC_ADDR_FF73,
      `GBC_ADDR_FF72,
      `GBC_ADDR_FF6C,
      `GBC_ADDR_RP,
      `GBC_ADDR_KEY1,
      `GBC_ADDR_SC,
      `GBC_ADDR_SB
   };

   logic page_match;
   logic both_low;

   assign page_match = (bus.addr[15:8] == `GBC_IO_PAGE);

   // Both strobes low at once is not a valid cycle
   assign both_low = !bus.we_l && !bus.re_l;

   always_comb begin
      access       = '0;
      access.wdata = bus.wdata;
      access.write = !bus.we_l && !both_low;
      access.read  = !bus.re_l && !both_low;

      // Flags stay set on a miss so the read still returns open bus
      if (page_match) begin
         for (int i = 0; i < `GBC_NUM_IOREGS; i++) begin
            if (bus.addr[7:0] == ADDR_TABLE[i]) begin
               access.hit  = 1'b1;
               access.slot = gbc_io_pkg::reg_idx_t'(i);
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: design/ioreg_file.sv
`default_nettype none

`include "gbc_io_params.svh"

module ioreg_file #(
   parameter int HEARTBEAT_BITS = `GBC_HEARTBEAT_BITS
) (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  gbc_io_pkg::reg_access_t access,
   output gbc_io_pkg::reg_bank_t   bank,
   output logic [7:0]              heartbeat
);

   // ==================================================
   // Per slot reset values and writable masks
   // ==================================================
   localparam gbc_io_pkg::reg_bank_t RST_VALUES = {
      `GBC_RST_FF77,
      `GBC_RST_FF76,
      `GBC_RST_FF75,
      `GBC_RST_FF74,
      `GBC_RST_FF73,
      `GBC_RST_FF72,
      `GBC_RST_FF6C,
      `GBC_RST_RP,
      `GBC_RST_KEY1,
      `GBC_RST_SC,
      `GBC_RST_SB
   };

   localparam gbc_io_pkg::reg_bank_t WMASK_VALUES = {
      `GBC_WMASK_FF77,
      `GBC_WMASK_FF76,
      `GBC_WMASK_FF75,
      `GBC_WMASK_FF74,
      `GBC_WMASK_FF73,
      `GBC_WMASK_FF72,
      `GBC_WMASK_FF6C,
      `GBC_WMASK_RP,
      `GBC_WMASK_KEY1,
      `GBC_WMASK_SC,
      `GBC_WMASK_SB
   };

   logic [HEARTBEAT_BITS-1:0] prescale;
   logic [7:0]                slot_mask;
   logic [7:0]                write_value;

   // Fixed bits keep their reset value
   assign slot_mask   = WMASK_VALUES[access.slot];
   assign write_value = (RST_VALUES[access.slot] & ~slot_mask)
                      | (access.wdata & slot_mask);

   // ==================================================
   // Register bank
   // ==================================================
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         bank <= RST_VALUES;
      end else if (access.write && access.hit) begin
         bank[access.slot] <= write_value;
      end
   end

   // Heartbeat steps when the prescaler rolls over
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         prescale  <= '0;
         heartbeat <= 8'h00;
      end else begin
         prescale <= prescale + 1'b1;
         if (prescale == '1) begin
            heartbeat <= heartbeat + 8'd1;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/ioreg_readback.sv
`default_nettype none

`include "gbc_io_params.svh"

module ioreg_readback (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  gbc_io_pkg::reg_access_t access,
   input  gbc_io_pkg::reg_bank_t   bank,
   input  logic [7:0]              heartbeat,
   input  logic [7:0]              debug_select,
   output logic [7:0]              read_data,
   output logic                    read_valid,
   output logic [7:0]              debug_value
);

   logic [7:0] read_next;
   logic [7:0] debug_next;

   // ==================================================
   // Bus readback
   // ==================================================

   // Unmapped addresses float high like an open bus
   assign read_next = access.hit ? bank[access.slot] : `GBC_OPEN_BUS;

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         read_valid <= 1'b0;
         read_data  <= 8'h00;
      end else begin
         read_valid <= access.read;
         if (access.read) begin
            read_data <= read_next;
         end
      end
   end

   // ==================================================
   // Debug view for the LEDs
   // ==================================================
   always_comb begin
      if (debug_select < 8'(`GBC_NUM_IOREGS)) begin
         debug_next = bank[gbc_io_pkg::reg_idx_t'(debug_select)];
      end else if (debug_select == 8'(`GBC_NUM_IOREGS)) begin
         // Heartbeat sits just past the last bank slot
         debug_next = heartbeat;
      end else begin
         debug_next = 8'h00;
      end
   end

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         debug_value <= 8'h00;
      end else begin
         debug_value <= debug_next;
      end
   end

endmodule

`default_nettype wire

// File: include/gbc_io_params.svh
`ifndef GBC_IO_PARAMS_SVH
`define GBC_IO_PARAMS_SVH

// ==================================================
// I/O page and bank size
// ==================================================
`define GBC_IO_PAGE          8'hFF
`define GBC_NUM_IOREGS       11
`define GBC_OPEN_BUS         8'hFF
`define GBC_HEARTBEAT_BITS   21

// Low address byte of each register, in slot order
`define GBC_ADDR_SB          8'h01
`define GBC_ADDR_SC          8'h02
`define GBC_ADDR_KEY1        8'h4D
`define GBC_ADDR_RP          8'h56
`define GBC_ADDR_FF6C        8'h6C
`define GBC_ADDR_FF72        8'h72
`define GBC_ADDR_FF73        8'h73
`define GBC_ADDR_FF74        8'h74
`define GBC_ADDR_FF75        8'h75
`define GBC_ADDR_FF76        8'h76
`define GBC_ADDR_FF77        8'h77

// ==================================================
// Reset values
// ==================================================
`define GBC_RST_SB           8'h00
`define GBC_RST_SC           8'h7C
`define GBC_RST_KEY1         8'hFD
`define GBC_RST_RP           8'h3E
`define GBC_RST_FF6C         8'hFE
`define GBC_RST_FF72         8'h00
`define GBC_RST_FF73         8'h00
`define GBC_RST_FF74         8'h00
`define GBC_RST_FF75         8'h8F
`define GBC_RST_FF76         8'h00
`define GBC_RST_FF77         8'h00

// Writable bits, a zero mask makes the slot read only
`define GBC_WMASK_SB         8'hFF
`define GBC_WMASK_SC         8'h83
`define GBC_WMASK_KEY1       8'h01
`define GBC_WMASK_RP         8'hC1
`define GBC_WMASK_FF6C       8'h01
`define GBC_WMASK_FF72       8'hFF
`define GBC_WMASK_FF73       8'hFF
`define GBC_WMASK_FF74       8'hFF
`define GBC_WMASK_FF75       8'h70
`define GBC_WMASK_FF76       8'h00
`define GBC_WMASK_FF77       8'h00

`endif

// File: verif/gbc_io_checker.sv
`default_nettype none

`include "gbc_io_params.svh"

module gbc_io_checker (
   input logic                    clock_in,
   input logic                    synch_reset,
   input gbc_io_pkg::reg_access_t access,
   input gbc_io_pkg::reg_bank_t   bank,
   input logic                    read_valid
);

   // Assertion failures so far
   int failures = 0;

   // ==================================================
   // Read pulse timing
   // ==================================================

   // A sampled read gives a pulse on the next cycle
   read_pulse_follows: assert property (
      @(posedge clock_in) disable iff (synch_reset)
      access.read |=> read_valid
   ) else begin
      $error("read_valid missing one cycle after a sampled read");
      failures++;
   end

   // No read sampled, so no pulse next cycle and no stretched pulse
   read_pulse_single: assert property (
      @(posedge clock_in) disable iff (synch_reset)
      !access.read |=> !read_valid
   ) else begin
      $error("read_valid high without a sampled read");
      failures++;
   end

   // ==================================================
   // Read-only slots
   // ==================================================
   read_only_stable: assert property (
      @(posedge clock_in) disable iff (synch_reset)
      1'b1 |=> ($stable(bank[`GBC_NUM_IOREGS-2]) && $stable(bank[`GBC_NUM_IOREGS-1]))
   ) else begin
      $error("read-only slot FF76 or FF77 changed");
      failures++;
   end

endmodule

`default_nettype wire

// File: verif/gbc_io_tb.sv
`default_nettype none

`include "gbc_io_params.svh"

module gbc_io_tb;

   localparam int NREG = `GBC_NUM_IOREGS;

   // Slot tables, slot 0 first
   localparam logic [7:0] ADDR_LO [NREG] = '{
      `GBC_ADDR_SB, `GBC_ADDR_SC, `GBC_ADDR_KEY1, `GBC_ADDR_RP, `GBC_ADDR_FF6C,
      `GBC_ADDR_FF72, `GBC_ADDR_FF73, `GBC_ADDR_FF74, `GBC_ADDR_FF75,
      `GBC_ADDR_FF76, `GBC_ADDR_FF77};
   localparam logic [7:0] RST_VAL [NREG] = '{
      `GBC_RST_SB, `GBC_RST_SC, `GBC_RST_KEY1, `GBC_RST_RP, `GBC_RST_FF6C,
      `GBC_RST_FF72, `GBC_RST_FF73, `GBC_RST_FF74, `GBC_RST_FF75,
      `GBC_RST_FF76, `GBC_RST_FF77};
   localparam logic [7:0] WMASK [NREG] = '{
      `GBC_WMASK_SB, `GBC_WMASK_SC, `GBC_WMASK_KEY1, `GBC_WMASK_RP, `GBC_WMASK_FF6C,
      `GBC_WMASK_FF72, `GBC_WMASK_FF73, `GBC_WMASK_FF74, `GBC_WMASK_FF75,
      `GBC_WMASK_FF76, `GBC_WMASK_FF77};

   logic                clock_in;
   logic                synch_reset;
   gbc_io_pkg::io_bus_t bus;
   logic [7:0]          debug_select;
   logic [7:0]          read_data;
   logic                read_valid;
   logic [7:0]          debug_value;
   logic [7:0]          model [NREG];
   int                  errors;
   int                  timeouts;
   integer              seed;

   gbc_io_top #(
      .HEARTBEAT_BITS (4)
   ) dut0 (
      .clock_in     (clock_in),
      .synch_reset  (synch_reset),
      .bus          (bus),
      .debug_select (debug_select),
      .read_data    (read_data),
      .read_valid   (read_valid),
      .debug_value  (debug_value)
   );

   bind ioreg_readback gbc_io_checker checker0 (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .access      (access),
      .bank        (bank),
      .read_valid  (read_valid)
   );

   always #50 clock_in = ~clock_in;

   // ==================================================
   // Bus helpers
   // ==================================================
   task automatic next_cycle();
      @(posedge clock_in);
      #5;
   endtask

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s gave %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Fixed bits keep their reset value
   function automatic logic [7:0] apply_mask(input int slot, input logic [7:0] data);
      return (RST_VAL[slot] & ~WMASK[slot]) | (data & WMASK[slot]);
   endfunction

   task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
      bus.addr  = addr;
      bus.wdata = data;
      bus.we_l  = 1'b0;
      next_cycle();
      bus.we_l = 1'b1;
   endtask

   task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
      int waited;
      bus.addr = addr;
      bus.re_l = 1'b0;
      next_cycle();
      bus.re_l = 1'b1;
      waited = 0;
      while (!read_valid && waited < 8) begin
         next_cycle();
         waited++;
      end
      if (!read_valid) begin
         timeouts++;
         $display("Timed out waiting for read_valid on address %h", addr);
      end
      data = read_data;
   endtask

   task automatic check_all_regs(input string what);
      logic [7:0] data;
      for (int i = 0; i < NREG; i++) begin
         bus_read({`GBC_IO_PAGE, ADDR_LO[i]}, data);
         check_byte($sformatf("%s, address FF%h", what, ADDR_LO[i]), data, model[i]);
      end
   endtask

   // ==================================================
   // Directed tests
   // ==================================================
   task automatic test_reset_values();
      check_all_regs("reset value");
   endtask

   task automatic test_write_readback();
      logic [31:0] rnd;
      logic [7:0]  data;
      for (int i = 0; i < NREG; i++) begin
         rnd = $random(seed);
         bus_write({`GBC_IO_PAGE, ADDR_LO[i]}, rnd[7:0]);
         model[i] = apply_mask(i, rnd[7:0]);
         bus_read({`GBC_IO_PAGE, ADDR_LO[i]}, data);
         check_byte($sformatf("readback of FF%h", ADDR_LO[i]), data, model[i]);
      end
   endtask

   task automatic test_open_bus();
      logic [7:0] data;
      bus_read(16'hFF03, data);
      check_byte("open bus read FF03", data, `GBC_OPEN_BUS);
      bus_read(16'hFE01, data);
      check_byte("open bus read FE01", data, `GBC_OPEN_BUS);
      bus_write(16'hFF03, 8'h5A);
      bus_write(16'hFE01, 8'hA5);
      check_all_regs("after missed writes");
   endtask

   // Reads issued every cycle in reverse slot order
   task automatic test_back_to_back();
      logic [7:0] expected [$];
      int         issued;
      int         received;
      int         cycles;
      issued   = 0;
      received = 0;
      cycles   = 0;
      while (received < NREG && cycles < NREG + 8) begin
         if (issued < NREG) begin
            bus.addr = {`GBC_IO_PAGE, ADDR_LO[NREG-1-issued]};
            bus.re_l = 1'b0;
            expected.push_back(model[NREG-1-issued]);
            issued++;
         end else begin
            bus.re_l = 1'b1;
         end
         next_cycle();
         cycles++;
         if (read_valid && expected.size() > 0) begin
            check_byte("back to back read", read_data, expected.pop_front());
            received++;
         end
      end
      bus.re_l = 1'b1;
      if (received != NREG) begin
         timeouts++;
         $display("Timed out with %0d of %0d back to back reads returned", received, NREG);
      end
      next_cycle();
      if (read_valid) begin
         errors++;
         $display("error at %0t: extra read_valid pulse after back to back reads", $time);
      end
   endtask

   task automatic test_debug_view();
      logic [7:0] first;
      logic [7:0] step;
      for (int i = 0; i < NREG; i++) begin
         debug_select = 8'(i);
         next_cycle();
         check_byte($sformatf("debug view of slot %0d", i), debug_value, model[i]);
      end
      debug_select = 8'(NREG);
      next_cycle();
      first = debug_value;
      repeat (64) @(posedge clock_in);
      #5;
      step = debug_value - first;
      if (step < 8'd3 || step > 8'd5) begin
         errors++;
         $display("error at %0t: heartbeat moved by %0d in 64 cycles, expected 4", $time, step);
      end
      debug_select = 8'(NREG + 1);
      next_cycle();
      check_byte("debug view past heartbeat", debug_value, 8'h00);
      debug_select = 8'hFF;
      next_cycle();
      check_byte("debug view select FF", debug_value, 8'h00);
      debug_select = 8'h00;
   endtask

   task automatic test_reset_restore();
      logic [31:0] rnd;
      for (int i = 0; i < NREG; i++) begin
         rnd = $random(seed);
         bus_write({`GBC_IO_PAGE, ADDR_LO[i]}, rnd[7:0]);
      end
      synch_reset = 1'b1;
      repeat (2) next_cycle();
      synch_reset = 1'b0;
      for (int i = 0; i < NREG; i++) begin
         model[i] = RST_VAL[i];
      end
      check_all_regs("after second reset");
      for (int i = 0; i < NREG; i++) begin
         debug_select = 8'(i);
         next_cycle();
         check_byte($sformatf("debug view after reset, slot %0d", i), debug_value, RST_VAL[i]);
      end
      debug_select = 8'h00;
   endtask

   // ==================================================
   // Test sequence
   // ==================================================
   initial begin
      clock_in     = 1'b0;
      synch_reset  = 1'b1;
      bus          = '0;
      bus.we_l     = 1'b1;
      bus.re_l     = 1'b1;
      debug_select = 8'h00;
      errors       = 0;
      timeouts     = 0;
      seed         = 32'h2af0;
      for (int i = 0; i < NREG; i++) begin
         model[i] = RST_VAL[i];
      end
      repeat (16) @(posedge clock_in);
      #5;
      synch_reset = 1'b0;

      test_reset_values();
      test_write_readback();
      test_open_bus();
      test_back_to_back();
      test_debug_view();
      test_reset_restore();

      $display("Checks finished with %0d errors, %0d timeouts and %0d assertion failures",
               errors, timeouts, dut0.readback0.checker0.failures);
      if (errors == 0 && timeouts == 0 && dut0.readback0.checker0.failures == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
design/gbc_io_pkg.sv
design/ioreg_decode.sv
design/ioreg_file.sv
design/ioreg_readback.sv
design/gbc_io_top.sv
verif/gbc_io_checker.sv
verif/gbc_io_tb.sv
